// ==== sifh_pkg.sv ====
`default_nettype none

package sifh_pkg;

    // time bin index of one photon
    localparam int BIN_W = 4;
    // pixel index within the array
    localparam int PIX_W = 2;
    // per-bin counter width
    localparam int COUNT_W = 8;
    // bank word address is pixel then bin
    localparam int ADDR_W = PIX_W + BIN_W;
    // words in one bank
    localparam int NUM_WORDS = 1 << ADDR_W;

    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [PIX_W-1:0]   pix_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // one photon arrival as seen at the input
    typedef struct packed {
        bin_t bin;
    } photon_event_t;

    // increment request towards the accumulator
    typedef struct packed {
        logic bank;
        pix_t pixel;
        bin_t bin;
    } acc_cmd_t;

    // one finished histogram word on the output port
    typedef struct packed {
        logic   bank;
        pix_t   pixel;
        bin_t   bin;
        count_t count;
    } hist_word_t;

    // acquisition sequencer states
    typedef enum logic [1:0] {
        SEQ_COLLECT,
        SEQ_FLUSH,
        SEQ_WAIT_DRAIN
    } seq_state_e;

    // readout handshake states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_PRESENT,
        RD_WAIT_ACK_LOW
    } rd_state_e;

endpackage

`default_nettype wire

// ==== hist_bank_ram.sv ====
`default_nettype none

module hist_bank_ram
    import sifh_pkg::*;
(
    input  logic   clk,
    input  logic   res,
    // port A, accumulator side
    input  logic   a_rd_bank,
    input  addr_t  a_rd_addr,
    output count_t a_rd_data,
    input  logic   a_wr_en,
    input  logic   a_wr_bank,
    input  addr_t  a_wr_addr,
    input  count_t a_wr_data,
    // port B, readout side
    input  logic   b_bank,
    input  addr_t  b_addr,
    output count_t b_rd_data,
    input  logic   b_clr
);

    // two banks of per-bin counts held in flops
    count_t mem [0:1][0:NUM_WORDS-1];

    // combinational reads on both ports
    assign a_rd_data = mem[a_rd_bank][a_rd_addr];
    assign b_rd_data = mem[b_bank][b_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole array back to empty histograms
            for (int b = 0; b < 2; b++) begin
                for (int w = 0; w < NUM_WORDS; w++) begin
                    mem[b][w] <= '0;
                end
            end
        end else begin
            if (a_wr_en) begin
                mem[a_wr_bank][a_wr_addr] <= a_wr_data;
            end
            // clear on read from the drain side
            if (b_clr) begin
                mem[b_bank][b_addr] <= '0;
            end
        end
    end

    // accumulate and drain must always sit in opposite banks
    a_bank_split: assert property (
        @(posedge clk) disable iff (!res)
        (a_wr_en && b_clr) |-> (a_wr_bank != b_bank)
    );

endmodule

`default_nettype wire

// ==== hist_acq_sequencer.sv ====
`default_nettype none

module hist_acq_sequencer
    import sifh_pkg::*;
#(
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQ_NUM          = 4
) (
    input  logic          clk,
    input  logic          res,
    input  logic          event_valid,
    input  photon_event_t event_data,
    output logic          event_ready,
    output logic          acc_valid,
    output acc_cmd_t      acc_cmd,
    output logic          his_num,
    output logic          drain_start,
    output logic          drain_bank,
    input  logic          drain_busy
);

    // counter widths, at least one bit even for a count of 1
    localparam int EV_W  = $clog2(EVENTS_PER_PIXEL + 1);
    localparam int ACQ_W = $clog2(ACQ_NUM + 1);

    seq_state_e       state;
    logic [EV_W-1:0]  ev_cnt;
    pix_t             pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             flush_cnt;
    logic             accept;
    logic             last_ev;
    logic             last_pix;
    logic             last_acq;
    logic             do_swap;

    // input open only while collecting
    assign event_ready = (state == SEQ_COLLECT);
    assign accept      = event_valid && event_ready;

    assign last_ev  = (ev_cnt == EV_W'(EVENTS_PER_PIXEL - 1));
    assign last_pix = (pix_cnt == '1);
    assign last_acq = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // swap once pipeline drained and readout free
    assign do_swap = !drain_busy &&
                     ((state == SEQ_FLUSH && flush_cnt) || state == SEQ_WAIT_DRAIN);

    // increment request goes out in the accept cycle
    assign acc_valid = accept;
    always_comb begin
        acc_cmd.bank  = his_num;
        acc_cmd.pixel = pix_cnt;
        acc_cmd.bin   = event_data.bin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= SEQ_COLLECT;
            ev_cnt      <= '0;
            pix_cnt     <= '0;
            acq_cnt     <= '0;
            flush_cnt   <= 1'b0;
            his_num     <= 1'b0;
            drain_start <= 1'b0;
            drain_bank  <= 1'b0;
        end else begin
            drain_start <= 1'b0;
            case (state)
                SEQ_COLLECT: begin
                    if (accept) begin
                        if (last_ev) begin
                            ev_cnt  <= '0;
                            // pixel index wraps by itself
                            pix_cnt <= pix_cnt + 1'b1;
                            if (last_pix) begin
                                if (last_acq) begin
                                    // histogram complete
                                    acq_cnt   <= '0;
                                    flush_cnt <= 1'b0;
                                    state     <= SEQ_FLUSH;
                                end else begin
                                    acq_cnt <= acq_cnt + 1'b1;
                                end
                            end
                        end else begin
                            ev_cnt <= ev_cnt + 1'b1;
                        end
                    end
                end
                SEQ_FLUSH: begin
                    // two quiet cycles let the accumulator retire
                    flush_cnt <= 1'b1;
                    if (flush_cnt && drain_busy) begin
                        state <= SEQ_WAIT_DRAIN;
                    end
                end
                SEQ_WAIT_DRAIN: begin
                    // old drain still running, hold input off
                end
                default: state <= SEQ_COLLECT;
            endcase
            if (do_swap) begin
                // hand old bank to readout
                drain_bank  <= his_num;
                drain_start <= 1'b1;
                his_num     <= ~his_num;
                state       <= SEQ_COLLECT;
            end
        end
    end

    // increments never target the bank being drained
    a_no_cmd_to_drain_bank: assert property (
        @(posedge clk) disable iff (!res)
        (acc_valid && drain_busy) |-> (acc_cmd.bank != drain_bank)
    );

endmodule

`default_nettype wire

// ==== hist_accumulator.sv ====
`default_nettype none

module hist_accumulator
    import sifh_pkg::*;
(
    input  logic     clk,
    input  logic     res,
    input  logic     acc_valid,
    input  acc_cmd_t acc_cmd,
    output addr_t    rd_addr,
    output logic     rd_bank,
    input  count_t   rd_data,
    output logic     wr_en,
    output logic     wr_bank,
    output addr_t    wr_addr,
    output count_t   wr_data
);

    // stage 1 reads, stage 2 writes back
    logic     s1_valid;
    logic     s2_valid;
    acc_cmd_t s1_cmd;
    acc_cmd_t s2_cmd;
    count_t   s1_cur;
    count_t   s1_next;
    count_t   s2_count;
    logic     fwd;

    // read address from the stage 1 request
    assign rd_bank = s1_cmd.bank;
    assign rd_addr = {s1_cmd.pixel, s1_cmd.bin};

    // same word about to be written, ram data is stale
    assign fwd    = s2_valid && (s2_cmd == s1_cmd);
    assign s1_cur = fwd ? s2_count : rd_data;

    // hold at full scale
    assign s1_next = (s1_cur == '1) ? s1_cur : s1_cur + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= acc_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            s1_cmd <= acc_cmd;
        end
        if (s1_valid) begin
            s2_cmd   <= s1_cmd;
            s2_count <= s1_next;
        end
    end

    // write back lands two edges after accept
    assign wr_en   = s2_valid;
    assign wr_bank = s2_cmd.bank;
    assign wr_addr = {s2_cmd.pixel, s2_cmd.bin};
    assign wr_data = s2_count;

    // back to back writes of one word step up unless at full scale
    a_count_monotonic: assert property (
        @(posedge clk) disable iff (!res)
        (wr_en && $past(wr_en) && wr_bank == $past(wr_bank) && wr_addr == $past(wr_addr))
            |-> (wr_data > $past(wr_data) || wr_data == '1)
    );

endmodule

`default_nettype wire

// ==== hist_readout.sv ====
`default_nettype none

module hist_readout
    import sifh_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       drain_start,
    input  logic       drain_bank,
    output logic       drain_busy,
    output logic       b_bank,
    output addr_t      b_addr,
    input  count_t     b_rd_data,
    output logic       b_clr,
    output logic       out_req,
    input  logic       out_ack,
    output hist_word_t out_word
);

    rd_state_e state;
    addr_t     addr;
    logic      bank_q;
    logic      load_word;

    assign drain_busy = (state != RD_IDLE);

    // idle looks at the bank about to be drained
    assign b_bank = (state == RD_IDLE) ? drain_bank : bank_q;
    assign b_addr = addr;

    // word leaves the bank once the receiver took it
    assign b_clr = (state == RD_PRESENT) && out_req && out_ack;

    // addr back at zero after the wrap means bank done
    assign load_word = (state == RD_IDLE && drain_start) ||
                       (state == RD_WAIT_ACK_LOW && !out_ack && addr != '0);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= RD_IDLE;
            addr    <= '0;
            bank_q  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (drain_start) begin
                        bank_q <= drain_bank;
                        state  <= RD_PRESENT;
                    end
                end
                RD_PRESENT: begin
                    // word already stable, now request
                    if (!out_req) begin
                        out_req <= 1'b1;
                    end else if (out_ack) begin
                        out_req <= 1'b0;
                        addr    <= addr + 1'b1;
                        state   <= RD_WAIT_ACK_LOW;
                    end
                end
                RD_WAIT_ACK_LOW: begin
                    // return to zero before the next word
                    if (!out_ack) begin
                        state <= (addr == '0) ? RD_IDLE : RD_PRESENT;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // output word registered one cycle ahead of req
    always_ff @(posedge clk) begin
        if (load_word) begin
            out_word.bank  <= b_bank;
            out_word.pixel <= b_addr[ADDR_W-1:BIN_W];
            out_word.bin   <= b_addr[BIN_W-1:0];
            out_word.count <= b_rd_data;
        end
    end

    // receiver may sample any time req is up
    a_word_stable: assert property (
        @(posedge clk) disable iff (!res)
        ($past(out_req) && out_req) |-> $stable(out_word)
    );

endmodule

`default_nettype wire

// ==== sifh_histogram_top.sv ====
`default_nettype none

module sifh_histogram_top
    import sifh_pkg::*;
#(
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQ_NUM          = 4
) (
    input  logic          clk,
    input  logic          res,
    input  logic          event_valid,
    input  photon_event_t event_data,
    output logic          event_ready,
    output logic          his_num,
    output logic          out_req,
    input  logic          out_ack,
    output hist_word_t    out_word
);

    // sequencer to accumulator
    logic     acc_valid;
    acc_cmd_t acc_cmd;
    // sequencer and readout
    logic     drain_start;
    logic     drain_bank;
    logic     drain_busy;
    // accumulator side of the ram
    addr_t    rd_addr;
    logic     rd_bank;
    count_t   rd_data;
    logic     wr_en;
    logic     wr_bank;
    addr_t    wr_addr;
    count_t   wr_data;
    // readout side of the ram
    logic     b_bank;
    addr_t    b_addr;
    count_t   b_rd_data;
    logic     b_clr;

    hist_acq_sequencer #(
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQ_NUM         (ACQ_NUM)
    ) u_seq (
        .clk        (clk),
        .res        (res),
        .event_valid(event_valid),
        .event_data (event_data),
        .event_ready(event_ready),
        .acc_valid  (acc_valid),
        .acc_cmd    (acc_cmd),
        .his_num    (his_num),
        .drain_start(drain_start),
        .drain_bank (drain_bank),
        .drain_busy (drain_busy)
    );

    hist_accumulator u_acc (
        .clk      (clk),
        .res      (res),
        .acc_valid(acc_valid),
        .acc_cmd  (acc_cmd),
        .rd_addr  (rd_addr),
        .rd_bank  (rd_bank),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    hist_bank_ram u_ram (
        .clk      (clk),
        .res      (res),
        .a_rd_bank(rd_bank),
        .a_rd_addr(rd_addr),
        .a_rd_data(rd_data),
        .a_wr_en  (wr_en),
        .a_wr_bank(wr_bank),
        .a_wr_addr(wr_addr),
        .a_wr_data(wr_data),
        .b_bank   (b_bank),
        .b_addr   (b_addr),
        .b_rd_data(b_rd_data),
        .b_clr    (b_clr)
    );

    hist_readout u_rd (
        .clk        (clk),
        .res        (res),
        .drain_start(drain_start),
        .drain_bank (drain_bank),
        .drain_busy (drain_busy),
        .b_bank     (b_bank),
        .b_addr     (b_addr),
        .b_rd_data  (b_rd_data),
        .b_clr      (b_clr),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_word   (out_word)
    );

endmodule

`default_nettype wire

// ==== tb_sifh_histogram.sv ====
`default_nettype none

module tb_sifh_histogram
    import sifh_pkg::*;
#(
    parameter int          EVENTS_PER_PIXEL = 8,
    parameter int          ACQ_NUM          = 4,
    parameter logic [31:0] SEED             = 32'h2d37283f
);

    localparam int NUM_PIX     = 1 << PIX_W;
    localparam int COUNT_MAX   = (1 << COUNT_W) - 1;
    localparam int EV_PER_HIST = EVENTS_PER_PIXEL * NUM_PIX * ACQ_NUM;
    // a single pixel and bin can only overflow with many acquisitions
    localparam bit SAT_RUN     = (EVENTS_PER_PIXEL * ACQ_NUM) > COUNT_MAX;
    // histograms completed over the whole run, plus half a histogram lost to reset
    localparam int RUN_HISTS   = SAT_RUN ? 1 : 9;
    localparam int RUN_EVENTS  = SAT_RUN ? EV_PER_HIST : RUN_HISTS * EV_PER_HIST + EV_PER_HIST / 2;
    localparam int WATCHDOG_CYCLES = RUN_EVENTS * 20 + RUN_HISTS * NUM_WORDS * 40 + 100;

    // stimulus modes
    localparam int MODE_RANDOM = 0;
    localparam int MODE_RUNS   = 1;
    localparam int MODE_FIXED  = 2;

    logic          clk = 1'b0;
    logic          res;
    logic          event_valid;
    photon_event_t event_data;
    logic          event_ready;
    logic          his_num;
    logic          out_req;
    logic          out_ack;
    hist_word_t    out_word;

    integer     seed;
    integer     ack_seed;
    int         ack_min;
    int         ack_span;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_err_start;
    int         stall_cycles;
    // bins accepted for the histogram being collected
    bin_t       hist_bins[$];
    // finished words still owed by the readout
    hist_word_t exp_words[$];
    logic       exp_bank;

    sifh_histogram_top #(
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQ_NUM         (ACQ_NUM)
    ) UUT (
        .clk        (clk),
        .res        (res),
        .event_valid(event_valid),
        .event_data (event_data),
        .event_ready(event_ready),
        .his_num    (his_num),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_word   (out_word)
    );

    always #2 clk = ~clk;

    // expected count for one word, from the accepted event list
    function automatic count_t ref_hist_count(input pix_t pixel, input bin_t bin);
        int n;
        int p;
        n = 0;
        for (int i = 0; i < hist_bins.size(); i++) begin
            // pixel steps every EVENTS_PER_PIXEL events and wraps per acquisition
            p = (i / EVENTS_PER_PIXEL) % NUM_PIX;
            if (p == int'(pixel) && hist_bins[i] == bin) begin
                n++;
            end
        end
        if (n > COUNT_MAX) begin
            n = COUNT_MAX;
        end
        return count_t'(n);
    endfunction

    function automatic int ack_delay();
        return ack_min + int'($unsigned($random(ack_seed)) % ack_span);
    endfunction

    task automatic check_word(input hist_word_t got, input hist_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: word got bank %0d pixel %0d bin %0d count %0d",
                     $time, got.bank, got.pixel, got.bin, got.count);
            $display("Mismatch at %0t: word expected bank %0d pixel %0d bin %0d count %0d",
                     $time, exp.bank, exp.pixel, exp.bin, exp.count);
        end
    endtask

    task automatic check_his_num(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: his_num is %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        res         <= 1'b0;
        event_valid <= 1'b0;
        repeat (5) @(posedge clk);
        // model forgets everything the DUT just lost
        hist_bins.delete();
        exp_words.delete();
        exp_bank = 1'b0;
        res <= 1'b1;
        @(posedge clk);
    endtask

    // hold one event until the DUT takes it
    task automatic send_event(input bin_t b);
        event_valid    <= 1'b1;
        event_data.bin <= b;
        @(posedge clk);
        while (!event_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic send_events(input int n, input int mode, input bin_t fixed_bin);
        bin_t b;
        int   run_left;
        b        = '0;
        run_left = 0;
        for (int i = 0; i < n; i++) begin
            if (mode == MODE_RANDOM) begin
                b = bin_t'($random(seed));
                // roughly one idle cycle in four
                if (($random(seed) & 3) == 0) begin
                    event_valid <= 1'b0;
                    @(posedge clk);
                end
            end else if (mode == MODE_RUNS) begin
                // same bin on back to back cycles
                if (run_left == 0) begin
                    b        = bin_t'($random(seed));
                    run_left = 1 + int'($unsigned($random(seed)) % 6);
                end
                run_left--;
            end else begin
                b = fixed_bin;
            end
            send_event(b);
        end
        event_valid <= 1'b0;
    endtask

    // flush then swap, input reopens with the new histogram number
    task automatic wait_swap();
        @(posedge clk);
        while (!event_ready) begin
            @(posedge clk);
        end
        check_his_num(his_num, exp_bank);
    endtask

    task automatic wait_drain();
        while (exp_words.size() != 0) begin
            @(posedge clk);
        end
        // last handshake back to zero
        while (out_req || out_ack) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test();
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - test_err_start);
        end
    endtask

    // reference model fed from accepted events
    always @(posedge clk) begin : event_monitor
        hist_word_t w;
        if (res && event_valid && event_ready) begin
            hist_bins.push_back(event_data.bin);
            if (hist_bins.size() == EV_PER_HIST) begin
                // histogram complete, queue the whole bank in address order
                for (int a = 0; a < NUM_WORDS; a++) begin
                    w.bank  = exp_bank;
                    w.pixel = pix_t'(a >> BIN_W);
                    w.bin   = bin_t'(a);
                    w.count = ref_hist_count(w.pixel, w.bin);
                    exp_words.push_back(w);
                end
                hist_bins.delete();
                exp_bank = ~exp_bank;
            end
        end
        if (res && event_valid && !event_ready) begin
            stall_cycles++;
        end
    end

    // one transfer per edge where req and ack are both high
    always @(posedge clk) begin : word_checker
        hist_word_t exp;
        if (res && out_req && out_ack) begin
            if (exp_words.size() == 0) begin
                errors++;
                $display("output word at %0t arrived with no finished histogram pending",
                         $time);
            end else begin
                exp = exp_words.pop_front();
                check_word(out_word, exp);
            end
        end
    end

    // four-phase receiver with random latency on both edges
    initial begin : ack_responder
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (res && out_req && !out_ack) begin
                repeat (ack_delay()) @(posedge clk);
                out_ack <= 1'b1;
            end else if (!out_req && out_ack) begin
                repeat (ack_delay()) @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main_sequence
        res          = 1'b0;
        event_valid  = 1'b0;
        event_data   = '0;
        seed         = SEED;
        ack_seed     = SEED ^ 32'h5a5a5a5a;
        ack_min      = 0;
        ack_span     = 3;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        stall_cycles = 0;
        exp_bank     = 1'b0;
        apply_reset();
        check_flag("event_ready after reset", event_ready, 1'b1);
        check_flag("out_req after reset", out_req, 1'b0);
        check_his_num(his_num, 1'b0);

        if (SAT_RUN) begin
            // every event into one bin, far past full scale
            start_test();
            send_events(EV_PER_HIST, MODE_FIXED, 4'h9);
            wait_swap();
            wait_drain();
            finish_test(5, "saturation");
        end else begin
            start_test();
            send_events(EV_PER_HIST, MODE_RANDOM, '0);
            wait_swap();
            wait_drain();
            finish_test(1, "single histogram");

            start_test();
            for (int h = 0; h < 3; h++) begin
                send_events(EV_PER_HIST, MODE_RANDOM, '0);
                wait_swap();
            end
            wait_drain();
            finish_test(2, "back to back histograms");

            // slow receiver keeps the readout busy past the next swap
            start_test();
            ack_min      = 6;
            ack_span     = 7;
            stall_cycles = 0;
            send_events(3 * EV_PER_HIST, MODE_RANDOM, '0);
            wait_swap();
            wait_drain();
            if (stall_cycles <= 2 * 3) begin
                errors++;
                $display("event_ready was never held low for a busy readout");
            end
            ack_min  = 0;
            ack_span = 3;
            finish_test(3, "slow readout back-pressure");

            start_test();
            send_events(EV_PER_HIST, MODE_RUNS, '0);
            wait_swap();
            wait_drain();
            finish_test(4, "repeated bins");

            // half a histogram, then reset throws it away
            start_test();
            send_events(EV_PER_HIST / 2, MODE_RANDOM, '0);
            repeat (3) @(posedge clk);
            apply_reset();
            check_his_num(his_num, 1'b0);
            check_flag("out_req after reset", out_req, 1'b0);
            send_events(EV_PER_HIST, MODE_RANDOM, '0);
            wait_swap();
            wait_drain();
            finish_test(6, "reset mid histogram");
        end

        if (hist_bins.size() != 0 || exp_words.size() != 0) begin
            errors++;
            $display("model left with %0d events and %0d words unaccounted",
                     hist_bins.size(), exp_words.size());
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
sifh_pkg.sv
hist_bank_ram.sv
hist_acq_sequencer.sv
hist_accumulator.sv
hist_readout.sv
sifh_histogram_top.sv
tb_sifh_histogram.sv

// ==== Makefile ====
# Verilator build and run for the histogram subsystem.
# Two builds: default parameters, and ACQ_NUM raised for the saturation test.

VERILATOR ?= verilator
TOP       ?= tb_sifh_histogram
FILELIST  ?= filelist.f
# 32'h2d37283f in decimal
SEED      ?= 758589503
SAT_ACQ   ?= 40
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build both configurations, run them, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST SEED SAT_ACQ LOG OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR)/default -f $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -GACQ_NUM=$(SAT_ACQ) \
		--Mdir $(OBJ_DIR)/sat -f $(FILELIST)

test: build
	@rm -f $(LOG)
	-./$(OBJ_DIR)/default/V$(TOP) >> $(LOG) 2>&1
	-./$(OBJ_DIR)/sat/V$(TOP) >> $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if [ "$$(grep -c 'Simulation passed' $(LOG))" -ne 2 ]; then \
		echo "test: FAIL, a run ended without a result"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
